// File: verilog/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// instruction field widths
`define OPCODE_W    6
`define FUNCT_W     6
`define REG_ADDR_W  5
`define ALU_CTRL_W  4

////////////////////////////////////////
// opcodes
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

////////////////////////////////////////
// funct codes of SPECIAL
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_MFHI     6'b010000
`define FN_MTHI     6'b010001
`define FN_MFLO     6'b010010
`define FN_MTLO     6'b010011
`define FN_MULT     6'b011000
`define FN_MULTU    6'b011001
`define FN_DIV      6'b011010
`define FN_DIVU     6'b011011
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

// REGIMM rt codes
`define RT_BLTZ     5'd0
`define RT_BGEZ     5'd1

////////////////////////////////////////
// control word field codes
`define ALU_AND     4'd0
`define ALU_OR      4'd1
`define ALU_ADD     4'd2
`define ALU_SUB     4'd3
`define ALU_XOR     4'd4
`define ALU_NOR     4'd5
`define ALU_SLL     4'd6
`define ALU_SRL     4'd7
`define ALU_SRA     4'd8
`define ALU_SLT     4'd9
`define ALU_SLTU    4'd10

`define EXT_SIGN    2'd0
`define EXT_ZERO    2'd1
`define EXT_LUI     2'd2

`define DST_RT      2'd0
`define DST_RD      2'd1
`define DST_RA      2'd2   // $31 for jal

`define WB_ALU      2'd0
`define WB_MEM      2'd1
`define WB_LINK     2'd2
`define WB_HILO     2'd3

`define PC_SEQ      2'd0
`define PC_REG      2'd1
`define PC_TARGET   2'd2

`define DATA_WORD   3'd0
`define DATA_LBU    3'd1
`define DATA_LB     3'd2
`define DATA_LHU    3'd3
`define DATA_LH     3'd4

`define MD_MULT     2'd0
`define MD_MULTU    2'd1
`define MD_DIV      2'd2
`define MD_DIVU     2'd3

`endif

// File: verilog/decode_pkg.sv
`default_nettype none

`include "decode_cfg.svh"

package decode_pkg;

    // instruction fields
    typedef logic [`OPCODE_W-1:0]   opcode_t;
    typedef logic [`FUNCT_W-1:0]    funct_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    ////////////////////////////////////////
    // control word fields
    typedef logic [`ALU_CTRL_W-1:0] alu_ctrl_t;
    typedef logic [1:0]             ext_op_t;     // EXT_*
    typedef logic [1:0]             reg_dst_t;    // DST_*
    typedef logic [1:0]             wb_sel_t;     // WB_*
    typedef logic [1:0]             pc_sel_t;     // PC_*
    typedef logic [1:0]             multdiv_op_t; // MD_*
    typedef logic [2:0]             data_op_t;    // load width and sign

endpackage

`default_nettype wire

// File: verilog/funct_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface funct_ctrl_if;
    import decode_pkg::*;

    alu_ctrl_t   alu_ctrl;
    logic        alu_a_shamt;  // shift amount from instr[10:6]
    logic        reg_write;
    wb_sel_t     wb_sel;
    pc_sel_t     pc_sel;
    multdiv_op_t multdiv_op;
    logic        start;
    logic        mthi;
    logic        mtlo;
    logic        mfhi;
    logic        mflo;

    modport source (
        output alu_ctrl, alu_a_shamt, reg_write, wb_sel, pc_sel,
        output multdiv_op, start, mthi, mtlo, mfhi, mflo
    );

    modport sink (
        input alu_ctrl, alu_a_shamt, reg_write, wb_sel, pc_sel,
        input multdiv_op, start, mthi, mtlo, mfhi, mflo
    );

endinterface

`default_nettype wire

// File: verilog/funct_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module funct_decoder (
    input  decode_pkg::funct_t func,
    funct_ctrl_if.source       ctrl
);

    ////////////////////////////////////////
    // ALU operation
    always_comb begin
        case (func)
            `FN_ADD, `FN_ADDU:  ctrl.alu_ctrl = `ALU_ADD;
            `FN_SUB, `FN_SUBU:  ctrl.alu_ctrl = `ALU_SUB;
            `FN_OR:             ctrl.alu_ctrl = `ALU_OR;
            `FN_XOR:            ctrl.alu_ctrl = `ALU_XOR;
            `FN_NOR:            ctrl.alu_ctrl = `ALU_NOR;
            `FN_SLL, `FN_SLLV:  ctrl.alu_ctrl = `ALU_SLL;
            `FN_SRL, `FN_SRLV:  ctrl.alu_ctrl = `ALU_SRL;
            `FN_SRA, `FN_SRAV:  ctrl.alu_ctrl = `ALU_SRA;
            `FN_SLT:            ctrl.alu_ctrl = `ALU_SLT;
            `FN_SLTU:           ctrl.alu_ctrl = `ALU_SLTU;
            default:            ctrl.alu_ctrl = `ALU_AND; // and, jumps, hi/lo, mult/div
        endcase
    end

    assign ctrl.alu_a_shamt = func inside {`FN_SLL, `FN_SRL, `FN_SRA};

    // jr, mthi/mtlo and mult/div leave the register file alone
    assign ctrl.reg_write = func inside {
        `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV,
        `FN_JALR, `FN_MFHI, `FN_MFLO,
        `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU,
        `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU
    };

    ////////////////////////////////////////
    // write-back, pc and hi/lo unit
    always_comb begin
        ctrl.wb_sel     = `WB_ALU;
        ctrl.pc_sel     = `PC_SEQ;
        ctrl.multdiv_op = `MD_MULT;
        ctrl.start      = 1'b0;
        ctrl.mthi       = 1'b0;
        ctrl.mtlo       = 1'b0;
        ctrl.mfhi       = 1'b0;
        ctrl.mflo       = 1'b0;
        case (func)
            `FN_JR:   ctrl.pc_sel = `PC_REG;
            `FN_JALR: begin
                ctrl.pc_sel = `PC_REG;
                ctrl.wb_sel = `WB_LINK;
            end
            `FN_MFHI: begin
                ctrl.wb_sel = `WB_HILO;
                ctrl.mfhi   = 1'b1;
            end
            `FN_MFLO: begin
                ctrl.wb_sel = `WB_HILO;
                ctrl.mflo   = 1'b1;
            end
            `FN_MTHI: ctrl.mthi = 1'b1;
            `FN_MTLO: ctrl.mtlo = 1'b1;
            `FN_MULT: ctrl.start = 1'b1;
            `FN_MULTU: begin
                ctrl.start      = 1'b1;
                ctrl.multdiv_op = `MD_MULTU;
            end
            `FN_DIV: begin
                ctrl.start      = 1'b1;
                ctrl.multdiv_op = `MD_DIV;
            end
            `FN_DIVU: begin
                ctrl.start      = 1'b1;
                ctrl.multdiv_op = `MD_DIVU;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/mem_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module mem_decoder (
    input  decode_pkg::opcode_t  op,
    output logic                 load,
    output logic                 store,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 sh,
    output logic                 sb,
    output decode_pkg::data_op_t data_op
);

    always_comb begin
        load    = 1'b0;
        store   = 1'b0;
        sh      = 1'b0;
        sb      = 1'b0;
        data_op = `DATA_WORD;
        case (op)
            `OP_LW:  load = 1'b1;
            `OP_LB: begin
                load    = 1'b1;
                data_op = `DATA_LB;
            end
            `OP_LBU: begin
                load    = 1'b1;
                data_op = `DATA_LBU;
            end
            `OP_LH: begin
                load    = 1'b1;
                data_op = `DATA_LH;
            end
            `OP_LHU: begin
                load    = 1'b1;
                data_op = `DATA_LHU;
            end
            `OP_SW:  store = 1'b1;
            `OP_SH: begin
                store = 1'b1;
                sh    = 1'b1;
            end
            `OP_SB: begin
                store = 1'b1;
                sb    = 1'b1;
            end
            default: ;
        endcase
    end

    assign mem_read  = load;
    assign mem_write = store;

endmodule

`default_nettype wire

// File: verilog/branch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module branch_decoder (
    input  decode_pkg::opcode_t   op,
    input  decode_pkg::reg_addr_t rt,
    output logic                  hit,
    output logic                  link,
    output logic                  beq,
    output logic                  bne,
    output logic                  blez,
    output logic                  bgtz,
    output logic                  bgez,
    output logic                  bltz,
    output logic                  jump,
    output decode_pkg::pc_sel_t   pc_sel
);

    always_comb begin
        hit  = 1'b1;
        link = 1'b0;
        beq  = 1'b0;
        bne  = 1'b0;
        blez = 1'b0;
        bgtz = 1'b0;
        bgez = 1'b0;
        bltz = 1'b0;
        jump = 1'b0;
        case (op)
            `OP_BEQ:  beq  = 1'b1;
            `OP_BNE:  bne  = 1'b1;
            `OP_BLEZ: blez = 1'b1;
            `OP_BGTZ: bgtz = 1'b1;
            `OP_REGIMM: begin  // unknown rt still counts as a hit
                bgez = (rt == `RT_BGEZ);
                bltz = (rt == `RT_BLTZ);
            end
            `OP_J:    jump = 1'b1;
            `OP_JAL: begin
                jump = 1'b1;
                link = 1'b1;
            end
            default:  hit = 1'b0;
        endcase
    end

    assign pc_sel = hit ? `PC_TARGET : `PC_SEQ;

endmodule

`default_nettype wire

// File: verilog/main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module main_decoder (
    input  decode_pkg::opcode_t     op,
    funct_ctrl_if.sink              fctl,
    input  logic                    br_hit,
    input  logic                    br_link,
    input  logic                    load,
    input  logic                    store,
    output decode_pkg::alu_ctrl_t   alu_ctrl,
    output decode_pkg::reg_dst_t    reg_dst,
    output logic                    alu_a_src,
    output logic                    alu_b_src,
    output logic                    reg_write,
    output decode_pkg::wb_sel_t     mem_to_reg,
    output decode_pkg::ext_op_t     ext_op,
    output decode_pkg::pc_sel_t     pc_sel_base,
    output decode_pkg::multdiv_op_t multdiv_op,
    output logic                    start,
    output logic                    mthi,
    output logic                    mtlo,
    output logic                    mfhi,
    output logic                    mflo
);

    logic imm_alu;

    assign imm_alu = op inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
                                `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};

    always_comb begin
        alu_ctrl    = `ALU_AND;
        reg_dst     = `DST_RT;
        alu_a_src   = 1'b0;
        alu_b_src   = 1'b0;
        reg_write   = 1'b0;
        mem_to_reg  = `WB_ALU;
        ext_op      = `EXT_SIGN;
        pc_sel_base = `PC_SEQ;
        multdiv_op  = `MD_MULT;
        start       = 1'b0;
        mthi        = 1'b0;
        mtlo        = 1'b0;
        mfhi        = 1'b0;
        mflo        = 1'b0;
        if (op == `OP_SPECIAL) begin  // R-type fields from funct
            alu_ctrl    = fctl.alu_ctrl;
            reg_dst     = `DST_RD;
            alu_a_src   = fctl.alu_a_shamt;
            reg_write   = fctl.reg_write;
            mem_to_reg  = fctl.wb_sel;
            pc_sel_base = fctl.pc_sel;
            multdiv_op  = fctl.multdiv_op;
            start       = fctl.start;
            mthi        = fctl.mthi;
            mtlo        = fctl.mtlo;
            mfhi        = fctl.mfhi;
            mflo        = fctl.mflo;
        end else if (br_hit) begin
            if (br_link) begin  // jal
                reg_dst    = `DST_RA;
                mem_to_reg = `WB_LINK;
                reg_write  = 1'b1;
            end
        end else if (load || store) begin  // base + offset
            alu_ctrl   = `ALU_ADD;
            alu_b_src  = 1'b1;
            reg_write  = load;
            mem_to_reg = load ? `WB_MEM : `WB_ALU;
        end else if (imm_alu) begin
            alu_b_src = 1'b1;
            reg_write = 1'b1;
            case (op)
                `OP_SLTI:  alu_ctrl = `ALU_SLT;
                `OP_SLTIU: alu_ctrl = `ALU_SLTU;
                `OP_ANDI:  alu_ctrl = `ALU_AND;
                `OP_ORI:   alu_ctrl = `ALU_OR;
                `OP_XORI:  alu_ctrl = `ALU_XOR;
                default:   alu_ctrl = `ALU_ADD;  // addi, addiu, lui
            endcase
            if (op inside {`OP_ANDI, `OP_ORI, `OP_XORI})
                ext_op = `EXT_ZERO;
            else if (op == `OP_LUI)
                ext_op = `EXT_LUI;
        end
    end

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  decode_pkg::opcode_t     op,
    input  decode_pkg::funct_t      func,
    input  decode_pkg::reg_addr_t   rt,
    output decode_pkg::alu_ctrl_t   alu_ctrl,
    output decode_pkg::reg_dst_t    reg_dst,
    output logic                    alu_a_src,
    output logic                    alu_b_src,
    output logic                    reg_write,
    output logic                    mem_read,
    output logic                    mem_write,
    output decode_pkg::wb_sel_t     mem_to_reg,
    output decode_pkg::ext_op_t     ext_op,
    output logic                    if_beq,
    output logic                    if_bne,
    output logic                    if_blez,
    output logic                    if_bgez,
    output logic                    if_bltz,
    output logic                    if_bgtz,
    output logic                    if_j,
    output decode_pkg::pc_sel_t     pc_sel,
    output logic                    if_sh,
    output logic                    if_sb,
    output decode_pkg::data_op_t    data_op,
    output decode_pkg::multdiv_op_t multdiv_op,
    output logic                    start,
    output logic                    if_mthi,
    output logic                    if_mtlo,
    output logic                    if_mfhi,
    output logic                    if_mflo
);
    import decode_pkg::*;

    pc_sel_t br_pc_sel;
    pc_sel_t pc_sel_base;
    logic    br_hit;
    logic    br_link;
    logic    load;
    logic    store;

    funct_ctrl_if fctl_if ();

    ////////////////////////////////////////
    // field decoders
    funct_decoder u_funct (
        .func (func),
        .ctrl (fctl_if.source)
    );

    mem_decoder u_mem (
        .op        (op),
        .load      (load),
        .store     (store),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .sh        (if_sh),
        .sb        (if_sb),
        .data_op   (data_op)
    );

    branch_decoder u_branch (
        .op     (op),
        .rt     (rt),
        .hit    (br_hit),
        .link   (br_link),
        .beq    (if_beq),
        .bne    (if_bne),
        .blez   (if_blez),
        .bgtz   (if_bgtz),
        .bgez   (if_bgez),
        .bltz   (if_bltz),
        .jump   (if_j),
        .pc_sel (br_pc_sel)
    );

    ////////////////////////////////////////
    // control word
    main_decoder u_main (
        .op          (op),
        .fctl        (fctl_if.sink),
        .br_hit      (br_hit),
        .br_link     (br_link),
        .load        (load),
        .store       (store),
        .alu_ctrl    (alu_ctrl),
        .reg_dst     (reg_dst),
        .alu_a_src   (alu_a_src),
        .alu_b_src   (alu_b_src),
        .reg_write   (reg_write),
        .mem_to_reg  (mem_to_reg),
        .ext_op      (ext_op),
        .pc_sel_base (pc_sel_base),
        .multdiv_op  (multdiv_op),
        .start       (start),
        .mthi        (if_mthi),
        .mtlo        (if_mtlo),
        .mfhi        (if_mfhi),
        .mflo        (if_mflo)
    );

    assign pc_sel = br_hit ? br_pc_sel : pc_sel_base;  // branch target wins

endmodule

`default_nettype wire

// File: dv/tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: dv/instr_decoder_assert.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder_assert (
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input logic start,
    input logic reg_write,
    input logic beq,
    input logic bne,
    input logic blez,
    input logic bgez,
    input logic bltz,
    input logic bgtz,
    input logic j
);

    int unsigned violations = 0;  // failed checks so far

    mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
        else begin
            violations++;
            $error("memory read and memory write are set together");
        end

    start_no_write: assert property (@(posedge clk) disable iff (rst) !(start && reg_write))
        else begin
            violations++;
            $error("mult/div start comes with a register write");
        end

    // jump counts as a branch flag
    one_branch: assert property (@(posedge clk) disable iff (rst)
        $countones({beq, bne, blez, bgez, bltz, bgtz, j}) <= 1)
        else begin
            violations++;
            $error("more than one branch flag is set");
        end

endmodule

`default_nettype wire

// File: dv/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module tb_top;
    import decode_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_VECTORS  = 251;  // 18 + 8 + 8 + 9 + 8 + 200
    localparam int TIMEOUT_NS   = (RESET_CYCLES + 20 * NUM_VECTORS) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h1396_85fb;

    typedef struct packed {
        alu_ctrl_t   alu_ctrl;
        reg_dst_t    reg_dst;
        logic        alu_a_src;
        logic        alu_b_src;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        wb_sel_t     mem_to_reg;
        ext_op_t     ext_op;
        logic        beq;
        logic        bne;
        logic        blez;
        logic        bgez;
        logic        bltz;
        logic        bgtz;
        logic        j;
        pc_sel_t     pc_sel;
        logic        sh;
        logic        sb;
        data_op_t    data_op;
        multdiv_op_t multdiv_op;
        logic        start;
        logic        mthi;
        logic        mtlo;
        logic        mfhi;
        logic        mflo;
    } ctrl_word_t;

    logic       clk;
    logic       rst;
    opcode_t    op;
    funct_t     func;
    reg_addr_t  rt;
    ctrl_word_t actual;

    tb_clk #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clk(clk));

    instr_decoder dut0 (
        .op         (op),
        .func       (func),
        .rt         (rt),
        .alu_ctrl   (actual.alu_ctrl),
        .reg_dst    (actual.reg_dst),
        .alu_a_src  (actual.alu_a_src),
        .alu_b_src  (actual.alu_b_src),
        .reg_write  (actual.reg_write),
        .mem_read   (actual.mem_read),
        .mem_write  (actual.mem_write),
        .mem_to_reg (actual.mem_to_reg),
        .ext_op     (actual.ext_op),
        .if_beq     (actual.beq),
        .if_bne     (actual.bne),
        .if_blez    (actual.blez),
        .if_bgez    (actual.bgez),
        .if_bltz    (actual.bltz),
        .if_bgtz    (actual.bgtz),
        .if_j       (actual.j),
        .pc_sel     (actual.pc_sel),
        .if_sh      (actual.sh),
        .if_sb      (actual.sb),
        .data_op    (actual.data_op),
        .multdiv_op (actual.multdiv_op),
        .start      (actual.start),
        .if_mthi    (actual.mthi),
        .if_mtlo    (actual.mtlo),
        .if_mfhi    (actual.mfhi),
        .if_mflo    (actual.mflo)
    );

    bind instr_decoder instr_decoder_assert u_assert (
        .clk       (tb_top.clk),
        .rst       (tb_top.rst),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .start     (start),
        .reg_write (reg_write),
        .beq       (if_beq),
        .bne       (if_bne),
        .blez      (if_blez),
        .bgez      (if_bgez),
        .bltz      (if_bltz),
        .bgtz      (if_bgtz),
        .j         (if_j)
    );

    ////////////////////////////////////////
    // defined code sets
    function automatic bit op_defined(opcode_t o);
        return o inside {`OP_SPECIAL, `OP_REGIMM, `OP_J, `OP_JAL, `OP_BEQ, `OP_BNE,
                         `OP_BLEZ, `OP_BGTZ, `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
                         `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI, `OP_LB, `OP_LH, `OP_LW,
                         `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW};
    endfunction

    function automatic bit funct_defined(funct_t f);
        return f inside {`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV,
                         `FN_JR, `FN_JALR, `FN_MFHI, `FN_MTHI, `FN_MFLO, `FN_MTLO,
                         `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU, `FN_ADD, `FN_ADDU,
                         `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR,
                         `FN_SLT, `FN_SLTU};
    endfunction

    function automatic bit is_multdiv_hilo(funct_t f);
        return f inside {`FN_MFHI, `FN_MTHI, `FN_MFLO, `FN_MTLO,
                         `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU};
    endfunction

    ////////////////////////////////////////
    // expected control word
    function automatic ctrl_word_t rtype_word(funct_t f);
        ctrl_word_t w;
        w = '0;
        w.reg_dst   = `DST_RD;
        w.reg_write = 1'b1;
        case (f)
            `FN_ADD, `FN_ADDU: w.alu_ctrl = `ALU_ADD;
            `FN_SUB, `FN_SUBU: w.alu_ctrl = `ALU_SUB;
            `FN_AND:           w.alu_ctrl = `ALU_AND;
            `FN_OR:            w.alu_ctrl = `ALU_OR;
            `FN_XOR:           w.alu_ctrl = `ALU_XOR;
            `FN_NOR:           w.alu_ctrl = `ALU_NOR;
            `FN_SLT:           w.alu_ctrl = `ALU_SLT;
            `FN_SLTU:          w.alu_ctrl = `ALU_SLTU;
            `FN_SLLV:          w.alu_ctrl = `ALU_SLL;
            `FN_SRLV:          w.alu_ctrl = `ALU_SRL;
            `FN_SRAV:          w.alu_ctrl = `ALU_SRA;
            `FN_SLL: begin
                w.alu_ctrl  = `ALU_SLL;
                w.alu_a_src = 1'b1;  // shamt
            end
            `FN_SRL: begin
                w.alu_ctrl  = `ALU_SRL;
                w.alu_a_src = 1'b1;
            end
            `FN_SRA: begin
                w.alu_ctrl  = `ALU_SRA;
                w.alu_a_src = 1'b1;
            end
            `FN_JR: begin
                w.pc_sel    = `PC_REG;
                w.reg_write = 1'b0;
            end
            `FN_JALR: begin
                w.pc_sel     = `PC_REG;
                w.mem_to_reg = `WB_LINK;
            end
            `FN_MFHI: begin
                w.mem_to_reg = `WB_HILO;
                w.mfhi       = 1'b1;
            end
            `FN_MFLO: begin
                w.mem_to_reg = `WB_HILO;
                w.mflo       = 1'b1;
            end
            `FN_MTHI: begin
                w.mthi      = 1'b1;
                w.reg_write = 1'b0;
            end
            `FN_MTLO: begin
                w.mtlo      = 1'b1;
                w.reg_write = 1'b0;
            end
            `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU: begin
                w.start     = 1'b1;
                w.reg_write = 1'b0;
                case (f)
                    `FN_MULTU: w.multdiv_op = `MD_MULTU;
                    `FN_DIV:   w.multdiv_op = `MD_DIV;
                    `FN_DIVU:  w.multdiv_op = `MD_DIVU;
                    default:   w.multdiv_op = `MD_MULT;
                endcase
            end
            default: w.reg_write = 1'b0;  // undefined funct
        endcase
        return w;
    endfunction

    function automatic ctrl_word_t expected_word(opcode_t o, funct_t f, reg_addr_t r);
        ctrl_word_t w;
        w = '0;
        case (o)
            `OP_SPECIAL: w = rtype_word(f);
            `OP_BEQ:     w.beq  = 1'b1;
            `OP_BNE:     w.bne  = 1'b1;
            `OP_BLEZ:    w.blez = 1'b1;
            `OP_BGTZ:    w.bgtz = 1'b1;
            `OP_REGIMM: begin
                w.bltz = (r == `RT_BLTZ);
                w.bgez = (r == `RT_BGEZ);
            end
            `OP_J:       w.j = 1'b1;
            `OP_JAL: begin
                w.j          = 1'b1;
                w.reg_dst    = `DST_RA;
                w.mem_to_reg = `WB_LINK;
                w.reg_write  = 1'b1;
            end
            `OP_LW, `OP_LB, `OP_LBU, `OP_LH, `OP_LHU: begin
                w.alu_ctrl   = `ALU_ADD;
                w.alu_b_src  = 1'b1;
                w.reg_write  = 1'b1;
                w.mem_read   = 1'b1;
                w.mem_to_reg = `WB_MEM;
                case (o)
                    `OP_LB:  w.data_op = `DATA_LB;
                    `OP_LBU: w.data_op = `DATA_LBU;
                    `OP_LH:  w.data_op = `DATA_LH;
                    `OP_LHU: w.data_op = `DATA_LHU;
                    default: w.data_op = `DATA_WORD;
                endcase
            end
            `OP_SW, `OP_SH, `OP_SB: begin
                w.alu_ctrl  = `ALU_ADD;
                w.alu_b_src = 1'b1;
                w.mem_write = 1'b1;
                w.sh        = (o == `OP_SH);
                w.sb        = (o == `OP_SB);
            end
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                w.alu_b_src = 1'b1;
                w.reg_write = 1'b1;
                case (o)
                    `OP_SLTI:  w.alu_ctrl = `ALU_SLT;
                    `OP_SLTIU: w.alu_ctrl = `ALU_SLTU;
                    `OP_ANDI: begin
                        w.alu_ctrl = `ALU_AND;
                        w.ext_op   = `EXT_ZERO;
                    end
                    `OP_ORI: begin
                        w.alu_ctrl = `ALU_OR;
                        w.ext_op   = `EXT_ZERO;
                    end
                    `OP_XORI: begin
                        w.alu_ctrl = `ALU_XOR;
                        w.ext_op   = `EXT_ZERO;
                    end
                    `OP_LUI: begin
                        w.alu_ctrl = `ALU_ADD;
                        w.ext_op   = `EXT_LUI;
                    end
                    default:   w.alu_ctrl = `ALU_ADD;  // addi, addiu
                endcase
            end
            default: ;  // inactive word
        endcase
        // every branch and jump opcode redirects the pc
        if (o inside {`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_REGIMM, `OP_J, `OP_JAL})
            w.pc_sel = `PC_TARGET;
        return w;
    endfunction

    ////////////////////////////////////////
    // drive one instruction and check it
    task automatic apply_vector(input string name, input opcode_t o, input funct_t f,
                                input reg_addr_t r);
        ctrl_word_t exp;
        @(posedge clk);
        #1;
        op   = o;
        func = f;
        rt   = r;
        @(posedge clk);
        exp = expected_word(o, f, r);
        assert (actual === exp)
        else begin
            $display("Error %s op=%b func=%b rt=%0d expected %h actual %h",
                     name, o, f, r, exp, actual);
            $display("TEST FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic test_rtype_alu();
        int i;
        for (i = 0; i < 64; i++) begin
            if (funct_defined(funct_t'(i)) && !is_multdiv_hilo(funct_t'(i)))
                apply_vector("rtype_alu", `OP_SPECIAL, funct_t'(i), reg_addr_t'($urandom));
        end
    endtask

    task automatic test_multdiv_hilo();
        int i;
        for (i = 0; i < 64; i++) begin
            if (is_multdiv_hilo(funct_t'(i)))
                apply_vector("multdiv_hilo", `OP_SPECIAL, funct_t'(i), reg_addr_t'($urandom));
        end
    endtask

    task automatic test_load_store();
        int i;
        for (i = 0; i < 64; i++) begin
            if (opcode_t'(i) inside {`OP_LW, `OP_LB, `OP_LBU, `OP_LH, `OP_LHU,
                                     `OP_SW, `OP_SH, `OP_SB})
                apply_vector("load_store", opcode_t'(i), funct_t'($urandom), 5'd0);
        end
    endtask

    task automatic test_branch_jump();
        apply_vector("branch_beq", `OP_BEQ, 6'h00, 5'd3);
        apply_vector("branch_bne", `OP_BNE, 6'h15, 5'd4);
        apply_vector("branch_blez", `OP_BLEZ, 6'h2a, 5'd0);
        apply_vector("branch_bgtz", `OP_BGTZ, 6'h3f, 5'd0);
        apply_vector("regimm_rt0", `OP_REGIMM, 6'h00, 5'd0);
        apply_vector("regimm_rt1", `OP_REGIMM, 6'h00, 5'd1);
        apply_vector("regimm_rt2", `OP_REGIMM, 6'h00, 5'd2);  // hit without a flag
        apply_vector("jump_j", `OP_J, 6'h08, 5'd9);
        apply_vector("jump_jal", `OP_JAL, 6'h09, 5'd31);
    endtask

    task automatic test_imm_alu();
        int i;
        for (i = `OP_ADDI; i <= `OP_LUI; i++)
            apply_vector("imm_alu", opcode_t'(i), funct_t'($urandom), reg_addr_t'($urandom));
    endtask

    task automatic test_undefined();
        int n;
        opcode_t o;
        funct_t f;
        for (n = 0; n < 200; n++) begin
            if (n % 2 == 0) begin
                do o = opcode_t'($urandom); while (op_defined(o));
                apply_vector("undefined_op", o, funct_t'($urandom), reg_addr_t'($urandom));
            end else begin
                do f = funct_t'($urandom); while (funct_defined(f));
                apply_vector("undefined_funct", `OP_SPECIAL, f, reg_addr_t'($urandom));
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        op         = '0;
        func       = '0;
        rt         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        test_rtype_alu();
        test_multdiv_hilo();
        test_load_store();
        test_branch_jump();
        test_imm_alu();
        test_undefined();
        #1;  // last edge's concurrent checks settle
        $display("TEST PASS");
        $finish;
    end

    // failures of the bound concurrent assertions
    initial begin
        wait (dut0.u_assert.violations != 0);
        $display("a concurrent assertion in the bound checker failed");
        $display("TEST FAIL");
        $fatal(1, "concurrent assertion failure");
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns", TIMEOUT_NS);
        $display("TEST FAIL");
        $fatal(1, "simulation timed out");
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/funct_ctrl_if.sv
verilog/funct_decoder.sv
verilog/mem_decoder.sv
verilog/branch_decoder.sv
verilog/main_decoder.sv
verilog/instr_decoder.sv
dv/tb_clk.sv
dv/instr_decoder_assert.sv
dv/tb_top.sv

// File: Bender.yml
package:
  name: instr_decoder

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/decode_pkg.sv
      - verilog/funct_ctrl_if.sv
      - verilog/funct_decoder.sv
      - verilog/mem_decoder.sv
      - verilog/branch_decoder.sv
      - verilog/main_decoder.sv
      - verilog/instr_decoder.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/tb_clk.sv
      - dv/instr_decoder_assert.sv
      - dv/tb_top.sv
